// ==== hdl/cpu_glue_pkg.sv ====
// Shared widths, ICB command and response structs, interrupt vector, power state enum

package cpu_glue_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int XLEN   = 32;   // Data path width
  localparam int ADDR_W = 16;   // ICB word address width

  ////////////////////////////////////////
  // ICB channels
  ////////////////////////////////////////

  // Command channel payload, driven by the master
  typedef struct packed {
    logic              read;    // 1 for a read, 0 for a write
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wmask;   // Byte enables for writes
  } icb_cmd_t;

  // Response channel payload
  typedef struct packed {
    logic            err;
    logic [XLEN-1:0] rdata;
  } icb_rsp_t;

  ////////////////////////////////////////
  // Interrupts and power
  ////////////////////////////////////////

  typedef struct packed {
    logic dbg;   // Debug request
    logic ext;   // External, from the PLIC side
    logic sft;   // Software
    logic tmr;   // Timer
  } irq_vec_t;

  typedef enum logic [1:0] {
    PWR_RUN   = 2'd0,
    PWR_SLEEP = 2'd1,
    PWR_WAKE  = 2'd2
  } pwr_state_e;

endpackage

// ==== hdl/pwr_ctrl_fsm.sv ====
// Interrupt synchronizer and RUN/SLEEP/WAKE core power state machine
`timescale 1ns/1ns

module pwr_ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_wfi,
  input  cpu_glue_pkg::irq_vec_t irq_a,
  output cpu_glue_pkg::irq_vec_t irq_r,
  output logic                   core_clk_en,
  output logic                   core_sleep
);
  import cpu_glue_pkg::*;

  irq_vec_t   irq_meta_q;   // First sync stage
  pwr_state_e state_q;
  pwr_state_e state_d;
  logic       irq_any;
  logic       clk_en_q;

  ////////////////////////////////////////
  // Interrupt synchronizer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      irq_meta_q <= '0;
      irq_r      <= '0;
    end else begin
      irq_meta_q <= irq_a;
      irq_r      <= irq_meta_q;
    end
  end

  assign irq_any = (irq_r != '0);   // Any source wakes the core

  ////////////////////////////////////////
  // Sleep state machine
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_RUN: begin
        // Pending interrupt blocks sleep entry
        if (core_wfi && !irq_any) begin
          state_d = PWR_SLEEP;
        end
      end
      PWR_SLEEP: begin
        if (irq_any) begin
          state_d = PWR_WAKE;
        end
      end
      PWR_WAKE: begin
        state_d = PWR_RUN;   // Clock already back on here
      end
      default: begin
        state_d = PWR_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= PWR_RUN;
      clk_en_q <= 1'b1;
    end else begin
      state_q  <= state_d;
      clk_en_q <= (state_d != PWR_SLEEP);   // Registered enable, glitch free
    end
  end

  assign core_clk_en = clk_en_q;
  assign core_sleep  = ~clk_en_q;

  // Enable flop must track the state register
  a_no_clk_in_sleep: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == PWR_SLEEP) |-> !core_clk_en
  );

endmodule

// ==== hdl/tcm_idle_timer.sv ====
// Idle cycle counter that drives ITCM light sleep
`timescale 1ns/1ns

module tcm_idle_timer #(
  parameter int IDLE_LIMIT = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic tcm_active,
  output logic itcm_ls
);

  localparam int CNT_W = $clog2(IDLE_LIMIT + 1);

  logic [CNT_W-1:0] idle_cnt_q;
  logic             at_limit;

  assign at_limit = (idle_cnt_q == CNT_W'(IDLE_LIMIT));

  // Saturating counter, cleared by any activity
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_cnt_q <= '0;
    end else if (tcm_active) begin
      idle_cnt_q <= '0;
    end else if (!at_limit) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  // Drops in the same cycle traffic shows up
  assign itcm_ls = at_limit && !tcm_active;

  a_cnt_saturates: assert property (
    @(posedge clk) disable iff (!rst_n)
    idle_cnt_q <= CNT_W'(IDLE_LIMIT)
  );

endmodule

// ==== hdl/itcm_ctrl.sv ====
// ITCM controller with IFU/LSU ICB arbiter, RAM port driver and response buffer
`timescale 1ns/1ns

module itcm_ctrl #(
  parameter int RAM_AW = 10
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            core_sleep,

  input  logic                            ifu_cmd_valid,
  output logic                            ifu_cmd_ready,
  input  cpu_glue_pkg::icb_cmd_t          ifu_cmd,
  output logic                            ifu_rsp_valid,
  input  logic                            ifu_rsp_ready,
  output cpu_glue_pkg::icb_rsp_t          ifu_rsp,

  input  logic                            lsu_cmd_valid,
  output logic                            lsu_cmd_ready,
  input  cpu_glue_pkg::icb_cmd_t          lsu_cmd,
  output logic                            lsu_rsp_valid,
  input  logic                            lsu_rsp_ready,
  output cpu_glue_pkg::icb_rsp_t          lsu_rsp,

  output logic                            ram_cs,
  output logic                            ram_we,
  output logic [RAM_AW-1:0]               ram_addr,
  output logic [cpu_glue_pkg::XLEN/8-1:0] ram_wem,
  output logic [cpu_glue_pkg::XLEN-1:0]   ram_din,
  input  logic [cpu_glue_pkg::XLEN-1:0]   ram_dout,
  output logic                            tcm_active
);
  import cpu_glue_pkg::*;

  icb_cmd_t        sel_cmd;
  icb_rsp_t        rsp;
  logic            can_accept;
  logic            ifu_go;
  logic            lsu_go;
  logic            cmd_go;
  logic            in_range;
  logic            rsp_ready_sel;
  logic [XLEN-1:0] rsp_data;

  // Response buffer
  logic            rsp_vld_q;
  logic            rsp_lsu_q;   // Owner, 1 for LSU
  logic            rsp_new_q;   // First response cycle, RAM data live
  logic            rsp_err_q;
  logic            rsp_rd_q;
  logic [XLEN-1:0] rdata_q;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  assign can_accept    = !rsp_vld_q;   // One command in flight
  assign lsu_cmd_ready = can_accept;
  assign ifu_cmd_ready = can_accept && !core_sleep && !lsu_cmd_valid;   // LSU first

  assign lsu_go  = lsu_cmd_valid && lsu_cmd_ready;
  assign ifu_go  = ifu_cmd_valid && ifu_cmd_ready;
  assign cmd_go  = lsu_go || ifu_go;
  assign sel_cmd = lsu_cmd_valid ? lsu_cmd : ifu_cmd;

  // Upper address bits must be clear
  assign in_range = ((sel_cmd.addr >> RAM_AW) == '0);

  ////////////////////////////////////////
  // RAM port
  ////////////////////////////////////////

  assign ram_cs   = cmd_go && in_range;
  assign ram_we   = ~sel_cmd.read;
  assign ram_addr = sel_cmd.addr[RAM_AW-1:0];
  assign ram_wem  = sel_cmd.wmask;
  assign ram_din  = sel_cmd.wdata;

  ////////////////////////////////////////
  // Response buffer
  ////////////////////////////////////////

  assign rsp_ready_sel = rsp_lsu_q ? lsu_rsp_ready : ifu_rsp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
      rsp_new_q <= 1'b0;
      rsp_lsu_q <= 1'b0;
    end else begin
      rsp_new_q <= cmd_go;
      if (cmd_go) begin
        rsp_vld_q <= 1'b1;
        rsp_lsu_q <= lsu_go;
      end else if (rsp_vld_q && rsp_ready_sel) begin
        rsp_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_go) begin
      rsp_err_q <= !in_range;
      rsp_rd_q  <= sel_cmd.read;
    end
    if (rsp_new_q) begin
      rdata_q <= ram_dout;   // Hold read data under back-pressure
    end
  end

  assign rsp_data  = rsp_new_q ? ram_dout : rdata_q;
  assign rsp.err   = rsp_err_q;
  assign rsp.rdata = (rsp_rd_q && !rsp_err_q) ? rsp_data : '0;

  assign ifu_rsp_valid = rsp_vld_q && !rsp_lsu_q;
  assign lsu_rsp_valid = rsp_vld_q && rsp_lsu_q;
  assign ifu_rsp       = rsp;
  assign lsu_rsp       = rsp;

  assign tcm_active = ifu_cmd_valid || lsu_cmd_valid || rsp_vld_q;

  a_no_cs_when_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    ram_cs |-> !rsp_vld_q
  );

  a_one_rsp_port: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ifu_rsp_valid && lsu_rsp_valid)
  );

  // Stalled response keeps its payload
  a_rsp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rsp_vld_q && !rsp_ready_sel) |=> (rsp_vld_q && $stable(rsp))
  );

endmodule

// ==== hdl/cpu_glue_top.sv ====
// Always-on CPU glue top level with power control, idle timer and ITCM controller
`timescale 1ns/1ns

module cpu_glue_top #(
  parameter int RAM_AW     = 10,   // ITCM RAM word address width
  parameter int IDLE_LIMIT = 8     // Idle cycles before ITCM light sleep
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // Core power and interrupts
  input  logic                          core_wfi,
  input  cpu_glue_pkg::irq_vec_t        irq_a,
  output cpu_glue_pkg::irq_vec_t        irq_r,
  output logic                          core_clk_en,

  // Instruction fetch ICB
  input  logic                          ifu_cmd_valid,
  output logic                          ifu_cmd_ready,
  input  cpu_glue_pkg::icb_cmd_t        ifu_cmd,
  output logic                          ifu_rsp_valid,
  input  logic                          ifu_rsp_ready,
  output cpu_glue_pkg::icb_rsp_t        ifu_rsp,

  // Load/store ICB
  input  logic                          lsu_cmd_valid,
  output logic                          lsu_cmd_ready,
  input  cpu_glue_pkg::icb_cmd_t        lsu_cmd,
  output logic                          lsu_rsp_valid,
  input  logic                          lsu_rsp_ready,
  output cpu_glue_pkg::icb_rsp_t        lsu_rsp,

  // ITCM RAM macro
  output logic                          ram_cs,
  output logic                          ram_we,
  output logic [RAM_AW-1:0]             ram_addr,
  output logic [cpu_glue_pkg::XLEN/8-1:0] ram_wem,
  output logic [cpu_glue_pkg::XLEN-1:0] ram_din,
  input  logic [cpu_glue_pkg::XLEN-1:0] ram_dout,
  output logic                          itcm_ls
);

  logic core_sleep;   // Core parked on WFI
  logic tcm_active;   // Any ITCM traffic this cycle

  pwr_ctrl_fsm u_pwr_ctrl_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .core_wfi    (core_wfi),
    .irq_a       (irq_a),
    .irq_r       (irq_r),
    .core_clk_en (core_clk_en),
    .core_sleep  (core_sleep)
  );

  tcm_idle_timer #(
    .IDLE_LIMIT (IDLE_LIMIT)
  ) u_tcm_idle_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .tcm_active (tcm_active),
    .itcm_ls    (itcm_ls)
  );

  itcm_ctrl #(
    .RAM_AW (RAM_AW)
  ) u_itcm_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_sleep    (core_sleep),
    .ifu_cmd_valid (ifu_cmd_valid),
    .ifu_cmd_ready (ifu_cmd_ready),
    .ifu_cmd       (ifu_cmd),
    .ifu_rsp_valid (ifu_rsp_valid),
    .ifu_rsp_ready (ifu_rsp_ready),
    .ifu_rsp       (ifu_rsp),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd       (lsu_cmd),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp       (lsu_rsp),
    .ram_cs        (ram_cs),
    .ram_we        (ram_we),
    .ram_addr      (ram_addr),
    .ram_wem       (ram_wem),
    .ram_din       (ram_din),
    .ram_dout      (ram_dout),
    .tcm_active    (tcm_active)
  );

endmodule

// ==== testbench/tb_cpu_glue.sv ====
// Testbench for cpu_glue_top with clock, reset, random ICB traffic, RAM and reference models
`timescale 1ns/1ns

module tb_cpu_glue;
  import cpu_glue_pkg::*;

  localparam int RAM_AW     = 10;
  localparam int IDLE_LIMIT = 8;
  localparam int RAM_WORDS  = 1 << RAM_AW;
  localparam int MAX_CYCLES = 6000;   // 200 LSU ops of ~10 cycles, plus short tests
  localparam logic [RAM_AW-1:0] WIN_MASK = 10'h21f;   // Small window for address reuse

  bit              clk = 1'b0;
  logic            rst_n = 1'b0;
  logic            core_wfi = 1'b0;
  irq_vec_t        irq_a = '0;
  irq_vec_t        irq_r;
  logic            core_clk_en;
  logic            ifu_cmd_valid = 1'b0;
  logic            ifu_cmd_ready;
  icb_cmd_t        ifu_cmd = '0;
  logic            ifu_rsp_valid;
  logic            ifu_rsp_ready = 1'b0;
  icb_rsp_t        ifu_rsp;
  logic            lsu_cmd_valid = 1'b0;
  logic            lsu_cmd_ready;
  icb_cmd_t        lsu_cmd = '0;
  logic            lsu_rsp_valid;
  logic            lsu_rsp_ready = 1'b0;
  icb_rsp_t        lsu_rsp;
  logic            ram_cs;
  logic            ram_we;
  logic [RAM_AW-1:0] ram_addr;
  logic [XLEN/8-1:0] ram_wem;
  logic [XLEN-1:0] ram_din;
  logic [XLEN-1:0] ram_dout = '0;
  logic            itcm_ls;

  logic [XLEN-1:0] ram_arr [RAM_WORDS];   // Memory behind the DUT
  logic [XLEN-1:0] ref_mem [RAM_WORDS];   // Reference, in accept order
  integer          seed = 32'h2b2f447b;
  int              cycle_cnt = 0;
  int              tb_errs = 0;
  int              mon_errs = 0;
  int              cs_cnt = 0;
  int              tests_run = 0;
  int              err_mark = 0;
  irq_vec_t        irq_hist [2] = '{default: '0};
  bit              pend [2] = '{default: 1'b0};   // Index 0 IFU, 1 LSU
  bit              stall [2] = '{default: 1'b0};
  icb_rsp_t        prev_rsp [2];

  cpu_glue_top #(
    .RAM_AW     (RAM_AW),
    .IDLE_LIMIT (IDLE_LIMIT)
  ) dut_i (
    .clk (clk), .rst_n (rst_n), .core_wfi (core_wfi), .irq_a (irq_a), .irq_r (irq_r),
    .core_clk_en (core_clk_en),
    .ifu_cmd_valid (ifu_cmd_valid), .ifu_cmd_ready (ifu_cmd_ready), .ifu_cmd (ifu_cmd),
    .ifu_rsp_valid (ifu_rsp_valid), .ifu_rsp_ready (ifu_rsp_ready), .ifu_rsp (ifu_rsp),
    .lsu_cmd_valid (lsu_cmd_valid), .lsu_cmd_ready (lsu_cmd_ready), .lsu_cmd (lsu_cmd),
    .lsu_rsp_valid (lsu_rsp_valid), .lsu_rsp_ready (lsu_rsp_ready), .lsu_rsp (lsu_rsp),
    .ram_cs (ram_cs), .ram_we (ram_we), .ram_addr (ram_addr), .ram_wem (ram_wem),
    .ram_din (ram_din), .ram_dout (ram_dout), .itcm_ls (itcm_ls)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checks and models
  ////////////////////////////////////////

  function automatic bit check_val(input string name, input logic [63:0] got, exp);
    check_val = 1'b0;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      check_val = 1'b1;
    end
  endfunction

  function automatic bit check_true(input bit cond, input string what);
    check_true = 1'b0;
    assert (cond) else begin
      $display("At %0t ns: %s", $time, what);
      check_true = 1'b1;
    end
  endfunction

  function automatic logic [XLEN-1:0] fill_word(input int a);
    return 32'(a) * 32'h9e3779b1 ^ 32'h0f1e2d3c;
  endfunction

  // Expected response from the range and byte-mask rules
  function automatic icb_rsp_t model_access(input icb_cmd_t c);
    icb_rsp_t r;
    r = '0;
    if ((c.addr >> RAM_AW) != 0) begin
      r.err = 1'b1;
    end else if (c.read) begin
      r.rdata = ref_mem[c.addr[RAM_AW-1:0]];
    end else begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (c.wmask[b]) ref_mem[c.addr[RAM_AW-1:0]][8*b +: 8] = c.wdata[8*b +: 8];
      end
    end
    return r;
  endfunction

  // Single-port RAM, read data one cycle after ram_cs
  always @(posedge clk) begin
    if (ram_cs && ram_we) begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (ram_wem[b]) ram_arr[ram_addr][8*b +: 8] <= ram_din[8*b +: 8];
      end
    end else if (ram_cs) begin
      ram_dout <= ram_arr[ram_addr];
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, run stopped", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Per-cycle protocol monitor, sampled mid-cycle
  always @(negedge clk) begin
    logic     v;
    logic     rdy;
    icb_rsp_t r;
    if (rst_n) begin
      if (ram_cs) cs_cnt++;
      mon_errs += check_true(!(ram_cs && itcm_ls), "itcm_ls high during a RAM access");
      mon_errs += check_true(core_clk_en || !ifu_cmd_ready, "IFU accepted while core sleeps");
      mon_errs += check_val("irq_r", 64'(irq_r), 64'(irq_hist[1]));
      for (int p = 0; p < 2; p++) begin
        v   = p ? lsu_rsp_valid : ifu_rsp_valid;
        rdy = p ? lsu_rsp_ready : ifu_rsp_ready;
        r   = p ? lsu_rsp : ifu_rsp;
        if (v) mon_errs += check_true(pend[p], "response without a command on its port");
        if (stall[p]) mon_errs += check_true(v && r == prev_rsp[p], "response changed while stalled");
        stall[p]    = v && !rdy;
        prev_rsp[p] = r;
        if (v && rdy) pend[p] = 1'b0;
        if (p ? (lsu_cmd_valid && lsu_cmd_ready) : (ifu_cmd_valid && ifu_cmd_ready)) pend[p] = 1'b1;
      end
    end
    irq_hist[1] = irq_hist[0];
    irq_hist[0] = irq_a;
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic wait_accept(input bit on_lsu);
    do @(negedge clk); while (on_lsu ? !lsu_cmd_ready : !ifu_cmd_ready);
    @(posedge clk);
    if (on_lsu) lsu_cmd_valid <= 1'b0;
    else ifu_cmd_valid <= 1'b0;
  endtask

  // Random back-pressure until the response is taken
  task automatic collect(input bit on_lsu, output icb_rsp_t r);
    logic [31:0] rnd;
    bit          got;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      if (on_lsu ? (lsu_rsp_valid && lsu_rsp_ready) : (ifu_rsp_valid && ifu_rsp_ready)) begin
        got = 1'b1;
        r   = on_lsu ? lsu_rsp : ifu_rsp;
      end else begin
        @(posedge clk);
        rnd = $random(seed);
        ifu_rsp_ready <= rnd[0];
        lsu_rsp_ready <= rnd[1];
      end
    end
  endtask

  task automatic transact(input bit on_lsu, input icb_cmd_t c);
    icb_rsp_t exp_rsp;
    icb_rsp_t got;
    exp_rsp = model_access(c);
    @(posedge clk);
    if (on_lsu) begin
      lsu_cmd_valid <= 1'b1;
      lsu_cmd       <= c;
    end else begin
      ifu_cmd_valid <= 1'b1;
      ifu_cmd       <= c;
    end
    wait_accept(on_lsu);
    collect(on_lsu, got);
    tb_errs += check_val(on_lsu ? "lsu_rsp" : "ifu_rsp", 64'(got), 64'(exp_rsp));
  endtask

  task automatic end_test(input string name);
    int now_errs;
    now_errs = tb_errs + mon_errs;
    $display("%-20s %s (%0d errors)", name, now_errs == err_mark ? "ok" : "failed",
             now_errs - err_mark);
    err_mark = now_errs;
    tests_run++;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    icb_cmd_t    c;
    icb_cmd_t    c2;
    icb_rsp_t    got;
    icb_rsp_t    exp_l;
    icb_rsp_t    exp_i;
    logic [31:0] rnd;
    int          n;
    int          cs_mark;
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_arr[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    tb_errs += check_val("ifu_rsp_valid", 64'(ifu_rsp_valid), 64'(0));
    tb_errs += check_val("lsu_rsp_valid", 64'(lsu_rsp_valid), 64'(0));
    tb_errs += check_val("ram_cs", 64'(ram_cs), 64'(0));
    tb_errs += check_val("itcm_ls", 64'(itcm_ls), 64'(0));
    tb_errs += check_val("irq_r", 64'(irq_r), 64'(0));
    tb_errs += check_val("core_clk_en", 64'(core_clk_en), 64'(1));
    end_test("reset state");

    for (int i = 0; i < 200; i++) begin
      rnd     = $random(seed);
      c.read  = rnd[31];
      c.wmask = rnd[27:24];
      c.addr  = ADDR_W'(rnd[RAM_AW-1:0] & WIN_MASK);
      c.wdata = $random(seed);
      transact(1'b1, c);
    end
    end_test("random lsu traffic");

    // LSU write and IFU read of one word in the same cycle
    c     = '{read: 1'b0, addr: 16'h0011, wdata: $random(seed), wmask: 4'hf};
    c2    = '{read: 1'b1, addr: 16'h0011, wdata: '0, wmask: '0};
    exp_l = model_access(c);
    exp_i = model_access(c2);
    @(posedge clk);
    lsu_cmd_valid <= 1'b1;
    lsu_cmd       <= c;
    ifu_cmd_valid <= 1'b1;
    ifu_cmd       <= c2;
    @(negedge clk);
    tb_errs += check_true(lsu_cmd_ready && !ifu_cmd_ready, "IFU offered the bus before LSU");
    @(posedge clk);
    lsu_cmd_valid <= 1'b0;
    collect(1'b1, got);
    tb_errs += check_val("lsu_rsp", 64'(got), 64'(exp_l));
    wait_accept(1'b0);
    collect(1'b0, got);
    tb_errs += check_val("ifu_rsp", 64'(got), 64'(exp_i));
    end_test("concurrent ports");

    cs_mark = cs_cnt;
    rnd     = $random(seed);
    transact(1'b1, '{read: 1'b1, addr: rnd[15:0] | 16'(1 << RAM_AW), wdata: '0, wmask: '0});
    transact(1'b1, '{read: 1'b0, addr: 16'h8000, wdata: rnd, wmask: 4'hf});
    tb_errs += check_val("ram_cs count", 64'(cs_cnt - cs_mark), 64'(0));
    end_test("out-of-range address");

    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!itcm_ls && n < IDLE_LIMIT + 4);
    tb_errs += check_val("idle cycles before itcm_ls", 64'(n - 1), 64'(IDLE_LIMIT));
    // Access straight out of light sleep, monitor sees ram_cs against itcm_ls
    transact(1'b1, '{read: 1'b1, addr: 16'h0011, wdata: '0, wmask: '0});
    end_test("light sleep");

    repeat (20) begin
      @(posedge clk);
      rnd = $random(seed);
      irq_a <= rnd[3:0];
    end
    @(posedge clk);
    irq_a <= '0;
    repeat (3) @(posedge clk);
    core_wfi <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (core_clk_en && n < 8);
    tb_errs += check_val("core_clk_en", 64'(core_clk_en), 64'(0));
    repeat (6) @(negedge clk);   // Monitor watches ifu_cmd_ready here
    @(posedge clk);
    core_wfi  <= 1'b0;
    irq_a.tmr <= 1'b1;
    for (int k = 1; k <= 3; k++) begin
      @(posedge clk);
      @(negedge clk);
      tb_errs += check_val("core_clk_en", 64'(core_clk_en), 64'(k == 3));
    end
    @(posedge clk);
    irq_a <= '0;
    repeat (4) @(negedge clk);
    end_test("sleep and wake");

    $display("Tests run: %0d, errors: %0d", tests_run, tb_errs + mon_errs);
    if (tb_errs + mon_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== cpu_glue.f ====
hdl/cpu_glue_pkg.sv
hdl/pwr_ctrl_fsm.sv
hdl/tcm_idle_timer.sv
hdl/itcm_ctrl.sv
hdl/cpu_glue_top.sv
testbench/tb_cpu_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f cpu_glue.f \
  --top-module tb_cpu_glue \
  -o tb_cpu_glue

./obj_dir/tb_cpu_glue | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
